// ==== sim.f ====
verilog/hbm_mgmt_pkg.sv
verilog/reg_bus_if.sv
verilog/status_sync.sv
verilog/reg_decoder.sv
verilog/hbm_reg_blk.sv
verilog/apb_bridge.sv
verilog/hbm_mgmt_top.sv
dv/hbm_mgmt_asserts.sv
dv/hbm_mgmt_tb.sv

// ==== Makefile ====
# Verilator simulation of the HBM management block

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module hbm_mgmt_tb -f sim.f -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// ==== dv/hbm_mgmt_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module hbm_mgmt_tb;
    import hbm_mgmt_pkg::*;

    localparam int TIMEOUT = 64;

    logic  clk;
    logic  rst_n;
    logic  host_req;
    logic  host_wr;
    addr_t host_addr;
    data_t host_wdata;
    data_t host_rdata;
    logic  host_ack;
    logic  host_err;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
    data_t prdata;
    logic  pready;
    logic  pslverr;
    logic  init_done;
    temp_t dram_temp;
    logic  dram_cattrip;
    logic  channel_rst;
    logic  cattrip_alarm;

    logic [31:0] lfsr = 32'h8df77aa6;
    data_t       apb_mem [64];
    logic        apb_seen;

    hbm_mgmt_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Random source
    // ----------------------------------------
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic data_t random_bits(input int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[DATA_W-2:0], next_bit()};
        end
        return v;
    endfunction

    // ----------------------------------------
    // APB slave model
    // ----------------------------------------
    initial begin
        int unsigned wait_left;
        pready    = 1'b0;
        pslverr   = 1'b0;
        prdata    = '0;
        wait_left = 0;
        for (int i = 0; i < 64; i++) begin
            apb_mem[i] = 32'hA5C3_0000 ^ (i * 32'h0101);
        end
        forever begin
            @(negedge clk);
            pready  = 1'b0;
            pslverr = 1'b0;
            if (psel && !penable) begin
                // 0 to 3 wait states per transfer
                wait_left = random_bits(2);
            end else if (psel && penable) begin
                if (wait_left == 0) begin
                    pready  = 1'b1;
                    pslverr = (paddr >= 12'hF00);
                    prdata  = apb_mem[paddr[7:2]];
                    if (pwrite && !pslverr) begin
                        apb_mem[paddr[7:2]] = pwdata;
                    end
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    // ----------------------------------------
    // Checks and host bus
    // ----------------------------------------
    task automatic check(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Test failed");
        $fatal(1, "timeout");
    endtask

    // One access, also notes whether psel rose meanwhile
    task automatic bus_access(input logic wr, input addr_t addr, input data_t wdata,
                              output data_t rdata, output logic err);
        int cnt;
        @(negedge clk);
        host_req   = 1'b1;
        host_wr    = wr;
        host_addr  = addr;
        host_wdata = wdata;
        @(negedge clk);
        host_req = 1'b0;
        apb_seen = psel;
        cnt      = 0;
        while (!host_ack) begin
            if (cnt == TIMEOUT) begin
                report_timeout("host_ack");
            end
            cnt++;
            @(negedge clk);
            apb_seen = apb_seen | psel;
        end
        rdata = host_rdata;
        err   = host_err;
    endtask

    task automatic host_write(input addr_t addr, input data_t data, input logic exp_err);
        data_t rd;
        logic  err;
        bus_access(1'b1, addr, data, rd, err);
        check("host_err", data_t'(err), data_t'(exp_err));
    endtask

    task automatic host_read(input addr_t addr, output data_t data, input logic exp_err);
        logic err;
        bus_access(1'b0, addr, '0, data, err);
        check("host_err", data_t'(err), data_t'(exp_err));
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_reset_state();
        data_t rd;
        check("channel_rst", data_t'(channel_rst), 32'h1);
        check("cattrip_alarm", data_t'(cattrip_alarm), 32'h0);
        host_read(REG_CONTROL, rd, 1'b0);
        check("REG_CONTROL", rd, 32'h1);
        host_read(REG_SCRATCH, rd, 1'b0);
        check("REG_SCRATCH", rd, 32'h0);
    endtask

    task automatic test_local_regs();
        data_t wd;
        data_t rd;
        for (int i = 0; i < 4; i++) begin
            wd = random_bits(32);
            host_write(REG_SCRATCH, wd, 1'b0);
            host_read(REG_SCRATCH, rd, 1'b0);
            check("REG_SCRATCH", rd, wd);
        end
        // Release the channel, then hold it again
        host_write(REG_CONTROL, 32'h0, 1'b0);
        host_read(REG_STATUS, rd, 1'b0);
        check("REG_STATUS", rd, 32'h0);
        check("channel_rst", data_t'(channel_rst), 32'h0);
        host_write(REG_CONTROL, 32'h1, 1'b0);
        host_read(REG_CONTROL, rd, 1'b0);
        check("REG_CONTROL", rd, 32'h1);
        check("channel_rst", data_t'(channel_rst), 32'h1);
    endtask

    task automatic test_status_path();
        data_t st;
        data_t ds;
        int    cnt;
        @(negedge clk);
        init_done = 1'b1;
        dram_temp = 7'h55;
        cnt = 0;
        host_read(REG_STATUS, st, 1'b0);
        host_read(REG_DRAM_STATUS, ds, 1'b0);
        while (!(st[1] && ds[6:0] == 7'h55)) begin
            if (cnt == TIMEOUT) begin
                report_timeout("DRAM status in the registers");
            end
            cnt++;
            host_read(REG_STATUS, st, 1'b0);
            host_read(REG_DRAM_STATUS, ds, 1'b0);
        end
        check("REG_STATUS", st, 32'h3);
        check("REG_DRAM_STATUS", ds, 32'h55);
    endtask

    task automatic test_sticky_alarm();
        data_t ds;
        int    cnt;
        @(negedge clk);
        dram_cattrip = 1'b1;
        // Hold the trip until the live flag shows up
        cnt = 0;
        host_read(REG_DRAM_STATUS, ds, 1'b0);
        while (!ds[8]) begin
            if (cnt == TIMEOUT) begin
                report_timeout("the live trip flag to set");
            end
            cnt++;
            host_read(REG_DRAM_STATUS, ds, 1'b0);
        end
        repeat (2) @(negedge clk);
        dram_cattrip = 1'b0;
        // Wait for the live flag to drop
        cnt = 0;
        host_read(REG_DRAM_STATUS, ds, 1'b0);
        while (ds[8]) begin
            if (cnt == TIMEOUT) begin
                report_timeout("the live trip flag to clear");
            end
            cnt++;
            host_read(REG_DRAM_STATUS, ds, 1'b0);
        end
        check("REG_DRAM_STATUS", ds, 32'h255);
        check("cattrip_alarm", data_t'(cattrip_alarm), 32'h1);
        host_write(REG_DRAM_STATUS, 32'h200, 1'b0);
        host_read(REG_DRAM_STATUS, ds, 1'b0);
        check("REG_DRAM_STATUS", ds, 32'h55);
        check("cattrip_alarm", data_t'(cattrip_alarm), 32'h0);
    endtask

    task automatic test_apb();
        addr_t addr;
        data_t wd;
        data_t rd;
        for (int i = 0; i < 8; i++) begin
            addr = APB_BASE + addr_t'(random_bits(8) << 2);
            wd   = random_bits(32);
            host_write(addr, wd, 1'b0);
            check("apb_mem", apb_mem[addr[7:2]], wd);
            host_read(addr, rd, 1'b0);
            check("host_rdata", rd, wd);
        end
        for (int i = 0; i < 8; i++) begin
            addr = APB_BASE + addr_t'(random_bits(8) << 2);
            host_read(addr, rd, 1'b0);
            check("host_rdata", rd, apb_mem[addr[7:2]]);
        end
        // Slave error region
        host_read(12'hF00, rd, 1'b1);
        host_write(12'hF44, 32'hDEAD_BEEF, 1'b1);
    endtask

    task automatic test_unmapped();
        data_t rd;
        host_read(12'h400, rd, 1'b1);
        check("host_rdata", rd, 32'h0);
        check("psel", data_t'(apb_seen), 32'h0);
    endtask

    initial begin
        rst_n        = 1'b1;
        host_req     = 1'b0;
        host_wr      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        init_done    = 1'b0;
        dram_temp    = '0;
        dram_cattrip = 1'b0;
        @(negedge clk);
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_local_regs();
        test_status_path();
        test_sticky_alarm();
        test_apb();
        test_unmapped();

        if (dut.u_asserts.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d assertion failures", dut.u_asserts.fail_count);
            $display("Test failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule : hbm_mgmt_tb

`default_nettype wire

// ==== dv/hbm_mgmt_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module hbm_mgmt_asserts (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  hbm_mgmt_pkg::addr_t paddr,
    input  hbm_mgmt_pkg::data_t pwdata,
    input  logic                pready,
    input  logic                host_ack,
    input  logic                channel_rst
);

    int unsigned fail_count = 0;

    // ----------------------------------------
    // APB port
    // ----------------------------------------
    penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel)
        else begin
            $error("penable high without psel");
            fail_count++;
        end

    // Request fields held until the slave is ready
    apb_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !pready |=> $stable(paddr) && $stable(pwdata))
        else begin
            $error("paddr or pwdata changed during a transfer");
            fail_count++;
        end

    host_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        host_ack |=> !host_ack)
        else begin
            $error("host_ack longer than one cycle");
            fail_count++;
        end

    // Memory channel stays held while in reset
    channel_rst_in_reset: assert property (@(posedge clk)
        !rst_n |-> channel_rst)
        else begin
            $error("channel_rst low during reset");
            fail_count++;
        end

endmodule : hbm_mgmt_asserts

bind hbm_mgmt_top hbm_mgmt_asserts u_asserts (
    .clk         ( clk ),
    .rst_n       ( rst_n ),
    .psel        ( psel ),
    .penable     ( penable ),
    .paddr       ( paddr ),
    .pwdata      ( pwdata ),
    .pready      ( pready ),
    .host_ack    ( host_ack ),
    .channel_rst ( channel_rst )
);

`default_nettype wire

// ==== verilog/hbm_mgmt_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module hbm_mgmt_top (
    input  logic                clk,
    input  logic                rst_n,

    // Host register bus
    input  logic                host_req,
    input  logic                host_wr,
    input  hbm_mgmt_pkg::addr_t host_addr,
    input  hbm_mgmt_pkg::data_t host_wdata,
    output hbm_mgmt_pkg::data_t host_rdata,
    output logic                host_ack,
    output logic                host_err,

    // APB management port
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output hbm_mgmt_pkg::addr_t paddr,
    output hbm_mgmt_pkg::data_t pwdata,
    input  hbm_mgmt_pkg::data_t prdata,
    input  logic                pready,
    input  logic                pslverr,

    // DRAM status, asynchronous
    input  logic                init_done,
    input  hbm_mgmt_pkg::temp_t dram_temp,
    input  logic                dram_cattrip,

    output logic                channel_rst,
    output logic                cattrip_alarm
);

    logic                init_done_s;
    hbm_mgmt_pkg::temp_t temp_s;
    logic                cattrip_s;

    reg_bus_if reg_bus ();
    reg_bus_if apb_bus ();

    // ----------------------------------------
    // Host access routing
    // ----------------------------------------
    reg_decoder i_reg_decoder (
        .clk        ( clk ),
        .rst_n      ( rst_n ),
        .host_req   ( host_req ),
        .host_wr    ( host_wr ),
        .host_addr  ( host_addr ),
        .host_wdata ( host_wdata ),
        .host_rdata ( host_rdata ),
        .host_ack   ( host_ack ),
        .host_err   ( host_err ),
        .reg_bus    ( reg_bus ),
        .apb_bus    ( apb_bus )
    );

    hbm_reg_blk i_hbm_reg_blk (
        .clk           ( clk ),
        .rst_n         ( rst_n ),
        .bus           ( reg_bus ),
        .init_done_s   ( init_done_s ),
        .temp_s        ( temp_s ),
        .cattrip_s     ( cattrip_s ),
        .channel_rst   ( channel_rst ),
        .cattrip_alarm ( cattrip_alarm )
    );

    apb_bridge i_apb_bridge (
        .clk     ( clk ),
        .rst_n   ( rst_n ),
        .bus     ( apb_bus ),
        .psel    ( psel ),
        .penable ( penable ),
        .pwrite  ( pwrite ),
        .paddr   ( paddr ),
        .pwdata  ( pwdata ),
        .prdata  ( prdata ),
        .pready  ( pready ),
        .pslverr ( pslverr )
    );

    // DRAM status into the clk domain
    status_sync i_status_sync (
        .clk         ( clk ),
        .rst_n       ( rst_n ),
        .init_done   ( init_done ),
        .temp        ( dram_temp ),
        .cattrip     ( dram_cattrip ),
        .init_done_s ( init_done_s ),
        .temp_s      ( temp_s ),
        .cattrip_s   ( cattrip_s )
    );

endmodule : hbm_mgmt_top

`default_nettype wire

// ==== verilog/apb_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module apb_bridge (
    input  logic                clk,
    input  logic                rst_n,

    reg_bus_if.target           bus,

    // APB management port
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output hbm_mgmt_pkg::addr_t paddr,
    output hbm_mgmt_pkg::data_t pwdata,
    input  hbm_mgmt_pkg::data_t prdata,
    input  logic                pready,
    input  logic                pslverr
);
    import hbm_mgmt_pkg::*;

    bridge_state_t state;
    logic          ack_q;
    logic          err_q;
    data_t         rdata_q;
    logic          start;
    logic          done;

    assign start = (state == BR_IDLE) && bus.req;
    assign done  = (state == BR_ACCESS) && pready;

    // ----------------------------------------
    // Phase FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= BR_IDLE;
            ack_q <= 1'b0;
        end else begin
            ack_q <= done;
            case (state)
                BR_IDLE:   if (bus.req) state <= BR_SETUP;
                BR_SETUP:  state <= BR_ACCESS;
                BR_ACCESS: if (pready) state <= BR_IDLE;
                default:   state <= BR_IDLE;
            endcase
        end
    end

    // Request held from setup until the slave is ready
    always_ff @(posedge clk) begin
        if (start) begin
            paddr  <= bus.addr;
            pwrite <= bus.wr;
            pwdata <= bus.wdata;
        end
        if (done) begin
            rdata_q <= prdata;
            err_q   <= pslverr;
        end
    end

    assign psel    = (state != BR_IDLE);
    assign penable = (state == BR_ACCESS);

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;
    assign bus.err   = err_q;

endmodule : apb_bridge

`default_nettype wire

// ==== verilog/hbm_reg_blk.sv ====
`timescale 1ns/10ps
`default_nettype none

module hbm_reg_blk (
    input  logic                clk,
    input  logic                rst_n,

    reg_bus_if.target           bus,

    // Synchronized DRAM status
    input  logic                init_done_s,
    input  hbm_mgmt_pkg::temp_t temp_s,
    input  logic                cattrip_s,

    output logic                channel_rst,
    output logic                cattrip_alarm
);
    import hbm_mgmt_pkg::*;

    logic  ctrl_rst;
    logic  alarm;
    data_t scratch;
    data_t rd_val;
    data_t rdata_q;
    logic  ack_q;
    logic  wr_en;

    assign wr_en = bus.req & bus.wr;

    // ----------------------------------------
    // Writable state
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_rst    <= 1'b1;
            scratch     <= '0;
            alarm       <= 1'b0;
            channel_rst <= 1'b1;
        end else begin
            if (wr_en && bus.addr == REG_CONTROL) begin
                ctrl_rst <= bus.wdata[0];
            end
            if (wr_en && bus.addr == REG_SCRATCH) begin
                scratch <= bus.wdata;
            end
            // Trip sets, write-one clears, set wins
            if (cattrip_s) begin
                alarm <= 1'b1;
            end else if (wr_en && bus.addr == REG_DRAM_STATUS && bus.wdata[9]) begin
                alarm <= 1'b0;
            end
            channel_rst <= ctrl_rst;
        end
    end

    assign cattrip_alarm = alarm;

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_comb begin
        rd_val = '0;
        case (bus.addr)
            REG_CONTROL:     rd_val[0] = ctrl_rst;
            REG_STATUS:      rd_val[1:0] = {init_done_s, channel_rst};
            REG_DRAM_STATUS: rd_val[9:0] = {alarm, cattrip_s, 1'b0, temp_s};
            REG_SCRATCH:     rd_val = scratch;
            default:         rd_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.req) begin
            rdata_q <= rd_val;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus.req;
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;
    // Local accesses never fail
    assign bus.err   = 1'b0;

endmodule : hbm_reg_blk

`default_nettype wire

// ==== verilog/reg_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_decoder (
    input  logic                clk,
    input  logic                rst_n,

    // Host side
    input  logic                host_req,
    input  logic                host_wr,
    input  hbm_mgmt_pkg::addr_t host_addr,
    input  hbm_mgmt_pkg::data_t host_wdata,
    output hbm_mgmt_pkg::data_t host_rdata,
    output logic                host_ack,
    output logic                host_err,

    // Targets
    reg_bus_if.initiator        reg_bus,
    reg_bus_if.initiator        apb_bus
);
    import hbm_mgmt_pkg::*;

    logic in_reg;
    logic in_apb;
    logic miss_ack;

    // Region decode
    assign in_reg = (host_addr <= REG_LIMIT);
    assign in_apb = (host_addr >= APB_BASE);

    // Both targets see the same request fields, only req is steered
    assign reg_bus.req   = host_req & in_reg;
    assign reg_bus.wr    = host_wr;
    assign reg_bus.addr  = host_addr;
    assign reg_bus.wdata = host_wdata;

    assign apb_bus.req   = host_req & in_apb;
    assign apb_bus.wr    = host_wr;
    assign apb_bus.addr  = host_addr;
    assign apb_bus.wdata = host_wdata;

    // Unmapped hole answers by itself one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miss_ack <= 1'b0;
        end else begin
            miss_ack <= host_req & ~in_reg & ~in_apb;
        end
    end

    // Response mux, only one target answers at a time
    assign host_ack   = reg_bus.ack | apb_bus.ack | miss_ack;
    assign host_err   = (reg_bus.ack & reg_bus.err) | (apb_bus.ack & apb_bus.err) | miss_ack;
    assign host_rdata = reg_bus.ack ? reg_bus.rdata :
                        apb_bus.ack ? apb_bus.rdata : '0;

endmodule : reg_decoder

`default_nettype wire

// ==== verilog/status_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module status_sync (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                init_done,
    input  hbm_mgmt_pkg::temp_t temp,
    input  logic                cattrip,

    output logic                init_done_s,
    output hbm_mgmt_pkg::temp_t temp_s,
    output logic                cattrip_s
);
    import hbm_mgmt_pkg::*;

    localparam int VEC_W = TEMP_W + 2;

    logic [VEC_W-1:0] meta;
    logic [VEC_W-1:0] sync;
    logic [VEC_W-1:0] held;

    // Two flop synchronizer, then a hold stage that only takes a settled word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta <= '0;
            sync <= '0;
            held <= '0;
        end else begin
            meta <= {init_done, temp, cattrip};
            sync <= meta;
            // Skip a temperature caught mid change
            if (sync == meta) begin
                held <= sync;
            end
        end
    end

    assign {init_done_s, temp_s, cattrip_s} = held;

endmodule : status_sync

`default_nettype wire

// ==== verilog/reg_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface reg_bus_if;
    import hbm_mgmt_pkg::*;

    // Request side, valid in the req cycle
    logic  req;
    logic  wr;
    addr_t addr;
    data_t wdata;

    // Response side, valid with the ack pulse
    data_t rdata;
    logic  ack;
    logic  err;

    modport initiator (
        output req, wr, addr, wdata,
        input  rdata, ack, err
    );

    modport target (
        input  req, wr, addr, wdata,
        output rdata, ack, err
    );

endinterface : reg_bus_if

`default_nettype wire

// ==== verilog/hbm_mgmt_pkg.sv ====
`default_nettype none

package hbm_mgmt_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;
    localparam int TEMP_W = 7;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [TEMP_W-1:0] temp_t;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    // Local registers live at 0x000..0x0FF, APB at 0x800..0xFFF
    localparam addr_t REG_LIMIT = 12'h0FF;
    localparam addr_t APB_BASE  = 12'h800;

    // Local register offsets
    localparam addr_t REG_CONTROL     = 12'h000;
    localparam addr_t REG_STATUS      = 12'h004;
    localparam addr_t REG_DRAM_STATUS = 12'h008;
    localparam addr_t REG_SCRATCH     = 12'h00C;

    // APB bridge FSM
    typedef enum logic [1:0] {
        BR_IDLE,
        BR_SETUP,
        BR_ACCESS
    } bridge_state_t;

endpackage : hbm_mgmt_pkg

`default_nettype wire
